//--- cmd_to_axi.f
source/axi_pkg.sv
source/usb_cmd_pkg.sv
source/bridge_if.sv
source/cmd_decoder.sv
source/axi_burst_engine.sv
source/response_framer.sv
source/cmd_to_axi.sv
tests/tb_clock_gen.sv
tests/axi_mem_slave.sv
tests/cmd_to_axi_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the cmd_to_axi testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f cmd_to_axi.f \
  --top-module cmd_to_axi_tb \
  --Mdir obj_dir -o sim_cmd_to_axi
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_cmd_to_axi)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

//--- source/axi_burst_engine.sv
`timescale 1ns/1ps

module axi_burst_engine #(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  s_tvalid_i,
  output logic                  s_tready_o,
  input  usb_cmd_pkg::byte_t    s_tdata_i,
  cmd_if.snk                    cmd_i,
  rsp_if.src                    rsp_o,
  output logic                  awvalid_o,
  input  logic                  awready_i,
  output logic [ADDR_WIDTH-1:0] awaddr_o,
  output axi_pkg::axi_id_t      awid_o,
  output axi_pkg::axi_len_t     awlen_o,
  output axi_pkg::axi_burst_t   awburst_o,
  output logic                  wvalid_o,
  input  logic                  wready_i,
  output axi_pkg::axi_data_t    wdata_o,
  output axi_pkg::axi_strb_t    wstrb_o,
  output logic                  wlast_o,
  input  logic                  bvalid_i,
  output logic                  bready_o,
  input  axi_pkg::axi_resp_t    bresp_i,
  input  axi_pkg::axi_id_t      bid_i,
  output logic                  arvalid_o,
  input  logic                  arready_i,
  output logic [ADDR_WIDTH-1:0] araddr_o,
  output axi_pkg::axi_id_t      arid_o,
  output axi_pkg::axi_len_t     arlen_o,
  output axi_pkg::axi_burst_t   arburst_o,
  input  logic                  rvalid_i,
  output logic                  rready_o,
  input  axi_pkg::axi_data_t    rdata_i,
  input  axi_pkg::axi_resp_t    rresp_i,
  input  axi_pkg::axi_id_t      rid_i,
  input  logic                  rlast_i
);
  import axi_pkg::*;
  import usb_cmd_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WADDR,
    ST_WDATA,
    ST_WRESP,
    ST_RADDR,
    ST_RDATA,
    ST_REJECT
  } state_t;

  state_t                state;
  logic [ADDR_WIDTH-1:0] addr_q;
  cmd_tag_t              tag_q;
  axi_len_t              len_q;
  axi_len_t              beat_cnt;   // W beats sent so far
  logic [1:0]            byte_idx;   // Next byte lane to fill
  axi_data_t             word_q;
  logic                  wvalid_q;   // Packed word waiting for W
  logic                  rsp_valid_q;
  logic                  ok_q;
  logic                  cmd_take;
  logic                  byte_take;
  logic                  w_take;
  logic                  b_take;
  logic                  rsp_take;

  assign cmd_i.cmd_ready = (state == ST_IDLE);
  assign cmd_take  = cmd_i.cmd_valid && cmd_i.cmd_ready;
  assign s_tready_o = (state == ST_WDATA) && !wvalid_q;
  assign byte_take = s_tvalid_i && s_tready_o;
  assign w_take    = wvalid_o && wready_i;
  assign b_take    = bvalid_i && bready_o;
  assign rsp_take  = rsp_o.rsp_valid && rsp_o.rsp_ready;

  assign awvalid_o = (state == ST_WADDR);
  assign awaddr_o  = addr_q;
  assign awid_o    = tag_q;
  assign awlen_o   = len_q;
  assign awburst_o = AXI_BURST_INCR;

  assign wvalid_o = wvalid_q;
  assign wdata_o  = word_q;
  assign wstrb_o  = '1;  // Whole words only
  assign wlast_o  = (beat_cnt == len_q);

  assign bready_o = (state == ST_WRESP) && !rsp_valid_q;

  assign arvalid_o = (state == ST_RADDR);
  assign araddr_o  = addr_q;
  assign arid_o    = tag_q;
  assign arlen_o   = len_q;
  assign arburst_o = AXI_BURST_INCR;

  // R goes straight through, stalled by the framer
  assign rready_o = (state == ST_RDATA) && rsp_o.rsp_ready;

  assign rsp_o.rsp_valid = (state == ST_RDATA) ? rvalid_i : rsp_valid_q;
  assign rsp_o.kind = (state == ST_RDATA)  ? KIND_RBEAT :
                      (state == ST_REJECT) ? KIND_REJECT : KIND_WSTAT;
  assign rsp_o.tag  = (state == ST_RDATA) ? rid_i : tag_q;
  assign rsp_o.ok   = (state == ST_RDATA) ? (rresp_i == AXI_RESP_OKAY) : ok_q;
  assign rsp_o.data = rdata_i;
  assign rsp_o.last = (state == ST_RDATA) ? rlast_i : 1'b1;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (cmd_take) begin
            if (cmd_i.reject) state <= ST_REJECT;
            else if (cmd_i.dir) state <= ST_RADDR;
            else state <= ST_WADDR;
          end
        end
        ST_WADDR:  if (awready_i) state <= ST_WDATA;
        ST_WDATA:  if (w_take && wlast_o) state <= ST_WRESP;
        ST_WRESP:  if (rsp_take) state <= ST_IDLE;
        ST_RADDR:  if (arready_i) state <= ST_RDATA;
        ST_RDATA:  if (rsp_take && rlast_i) state <= ST_IDLE;
        ST_REJECT: if (rsp_take) state <= ST_IDLE;
        default:   state <= ST_IDLE;
      endcase
    end
  end

  // Byte packing and beat count
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      byte_idx <= '0;
      wvalid_q <= 1'b0;
      beat_cnt <= '0;
    end else begin
      if (cmd_take) begin
        byte_idx <= '0;
        beat_cnt <= '0;
      end
      if (byte_take) begin
        byte_idx <= byte_idx + 2'd1;
        if (byte_idx == 2'd3) wvalid_q <= 1'b1;  // Word complete
      end
      if (w_take) begin
        wvalid_q <= 1'b0;
        beat_cnt <= beat_cnt + 8'd1;
      end
    end
  end

  // Status for write and reject frames
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      rsp_valid_q <= 1'b0;
    end else if (b_take || (cmd_take && cmd_i.reject)) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_take) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (cmd_take) begin
      addr_q <= cmd_i.addr;
      tag_q  <= cmd_i.tag;
      len_q  <= cmd_i.len;
      ok_q   <= 1'b0;
    end
    if (b_take) begin
      tag_q <= bid_i;
      ok_q  <= (bresp_i == AXI_RESP_OKAY);
    end
    if (byte_take) word_q[{byte_idx, 3'b000} +: 8] <= s_tdata_i;  // LSB first
  end

endmodule

//--- source/axi_pkg.sv
package axi_pkg;

  typedef logic [31:0] axi_data_t;  // One W or R beat
  typedef logic [3:0]  axi_strb_t;  // One bit per byte lane
  typedef logic [3:0]  axi_id_t;    // Carries the command tag
  typedef logic [7:0]  axi_len_t;   // Beats minus one
  typedef logic [1:0]  axi_burst_t;
  typedef logic [1:0]  axi_resp_t;

  localparam axi_burst_t AXI_BURST_INCR = 2'b01;
  localparam axi_resp_t  AXI_RESP_OKAY  = 2'b00;

  // Byte lanes per data beat
  localparam int AXI_BYTES_PER_BEAT = 4;

endpackage

//--- source/bridge_if.sv
`timescale 1ns/1ps

// Decoded command, decoder to engine
interface cmd_if #(
  parameter int ADDR_WIDTH = 32
);
  import axi_pkg::*;
  import usb_cmd_pkg::*;

  logic                  cmd_valid;
  logic                  cmd_ready;
  logic                  dir;     // 1 for read
  cmd_tag_t              tag;
  axi_len_t              len;
  logic [ADDR_WIDTH-1:0] addr;    // Byte address
  logic                  reject;  // Burst crosses 4 KB

  modport src (output cmd_valid, dir, tag, len, addr, reject, input cmd_ready);
  modport snk (input cmd_valid, dir, tag, len, addr, reject, output cmd_ready);

endinterface

// Status and read beats, engine to framer
interface rsp_if;
  import axi_pkg::*;
  import usb_cmd_pkg::*;

  logic      rsp_valid;
  logic      rsp_ready;
  rsp_kind_t kind;
  cmd_tag_t  tag;
  logic      ok;    // Response was OKAY
  axi_data_t data;
  logic      last;  // Final beat of the command

  modport src (output rsp_valid, kind, tag, ok, data, last, input rsp_ready);
  modport snk (input rsp_valid, kind, tag, ok, data, last, output rsp_ready);

endinterface

//--- source/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder #(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                   aclk,
  input  logic                   aresetn,
  input  logic                   cmd_valid_i,
  output logic                   cmd_ready_o,
  input  logic                   cmd_dir_i,
  input  usb_cmd_pkg::cmd_tag_t  cmd_tag_i,
  input  axi_pkg::axi_len_t      cmd_len_i,
  input  usb_cmd_pkg::cmd_waddr_t cmd_addr_i,
  cmd_if.src                     cmd_o
);
  import axi_pkg::*;
  import usb_cmd_pkg::*;

  localparam int BEAT_SHIFT = $clog2(AXI_BYTES_PER_BEAT);

  logic                  valid_q;
  logic                  dir_q;
  cmd_tag_t              tag_q;
  axi_len_t              len_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic                  reject_q;
  logic [10:0]           end_word;  // Last word offset inside the 4 KB page

  assign end_word    = {1'b0, cmd_addr_i[9:0]} + {3'b000, cmd_len_i};
  assign cmd_ready_o = !valid_q;  // One entry only

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      valid_q <= 1'b0;
    end else if (cmd_valid_i && cmd_ready_o) begin
      valid_q <= 1'b1;
    end else if (cmd_o.cmd_ready) begin
      valid_q <= 1'b0;  // Engine took the entry
    end
  end

  always_ff @(posedge aclk) begin
    if (cmd_valid_i && cmd_ready_o) begin
      dir_q    <= cmd_dir_i;
      tag_q    <= cmd_tag_i;
      len_q    <= cmd_len_i;
      addr_q   <= ADDR_WIDTH'(cmd_addr_i) << BEAT_SHIFT;
      reject_q <= end_word[10];
    end
  end

  assign cmd_o.cmd_valid = valid_q;
  assign cmd_o.dir       = dir_q;
  assign cmd_o.tag       = tag_q;
  assign cmd_o.len       = len_q;
  assign cmd_o.addr      = addr_q;
  assign cmd_o.reject    = reject_q;

endmodule

//--- source/cmd_to_axi.sv
`timescale 1ns/1ps

module cmd_to_axi #(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                    aclk,
  input  logic                    aresetn,
  // Command channel
  input  logic                    cmd_valid_i,
  output logic                    cmd_ready_o,
  input  logic                    cmd_dir_i,
  input  usb_cmd_pkg::cmd_tag_t   cmd_tag_i,
  input  axi_pkg::axi_len_t       cmd_len_i,
  input  usb_cmd_pkg::cmd_waddr_t cmd_addr_i,
  // Bulk-Out bytes
  input  logic                    s_tvalid_i,
  output logic                    s_tready_o,
  input  usb_cmd_pkg::byte_t      s_tdata_i,
  // Bulk-In frames
  output logic                    m_tvalid_o,
  input  logic                    m_tready_i,
  output usb_cmd_pkg::byte_t      m_tdata_o,
  output logic                    m_tlast_o,
  // AXI4 master
  output logic                    awvalid_o,
  input  logic                    awready_i,
  output logic [ADDR_WIDTH-1:0]   awaddr_o,
  output axi_pkg::axi_id_t        awid_o,
  output axi_pkg::axi_len_t       awlen_o,
  output axi_pkg::axi_burst_t     awburst_o,
  output logic                    wvalid_o,
  input  logic                    wready_i,
  output axi_pkg::axi_data_t      wdata_o,
  output axi_pkg::axi_strb_t      wstrb_o,
  output logic                    wlast_o,
  input  logic                    bvalid_i,
  output logic                    bready_o,
  input  axi_pkg::axi_resp_t      bresp_i,
  input  axi_pkg::axi_id_t        bid_i,
  output logic                    arvalid_o,
  input  logic                    arready_i,
  output logic [ADDR_WIDTH-1:0]   araddr_o,
  output axi_pkg::axi_id_t        arid_o,
  output axi_pkg::axi_len_t       arlen_o,
  output axi_pkg::axi_burst_t     arburst_o,
  input  logic                    rvalid_i,
  output logic                    rready_o,
  input  axi_pkg::axi_data_t      rdata_i,
  input  axi_pkg::axi_resp_t      rresp_i,
  input  axi_pkg::axi_id_t        rid_i,
  input  logic                    rlast_i
);

  cmd_if #(.ADDR_WIDTH(ADDR_WIDTH)) cmd_bus ();
  rsp_if rsp_bus ();

  cmd_decoder #(.ADDR_WIDTH(ADDR_WIDTH)) cmd_decoder_inst (
    .aclk(aclk), .aresetn(aresetn),
    .cmd_valid_i(cmd_valid_i), .cmd_ready_o(cmd_ready_o), .cmd_dir_i(cmd_dir_i),
    .cmd_tag_i(cmd_tag_i), .cmd_len_i(cmd_len_i), .cmd_addr_i(cmd_addr_i),
    .cmd_o(cmd_bus.src)
  );

  axi_burst_engine #(.ADDR_WIDTH(ADDR_WIDTH)) axi_burst_engine_inst (
    .aclk(aclk), .aresetn(aresetn),
    .s_tvalid_i(s_tvalid_i), .s_tready_o(s_tready_o), .s_tdata_i(s_tdata_i),
    .cmd_i(cmd_bus.snk), .rsp_o(rsp_bus.src),
    .awvalid_o(awvalid_o), .awready_i(awready_i), .awaddr_o(awaddr_o),
    .awid_o(awid_o), .awlen_o(awlen_o), .awburst_o(awburst_o),
    .wvalid_o(wvalid_o), .wready_i(wready_i), .wdata_o(wdata_o),
    .wstrb_o(wstrb_o), .wlast_o(wlast_o),
    .bvalid_i(bvalid_i), .bready_o(bready_o), .bresp_i(bresp_i), .bid_i(bid_i),
    .arvalid_o(arvalid_o), .arready_i(arready_i), .araddr_o(araddr_o),
    .arid_o(arid_o), .arlen_o(arlen_o), .arburst_o(arburst_o),
    .rvalid_i(rvalid_i), .rready_o(rready_o), .rdata_i(rdata_i),
    .rresp_i(rresp_i), .rid_i(rid_i), .rlast_i(rlast_i)
  );

  response_framer response_framer_inst (
    .aclk(aclk), .aresetn(aresetn),
    .rsp_i(rsp_bus.snk),
    .m_tvalid_o(m_tvalid_o), .m_tready_i(m_tready_i),
    .m_tdata_o(m_tdata_o), .m_tlast_o(m_tlast_o)
  );

endmodule

//--- source/response_framer.sv
`timescale 1ns/1ps

module response_framer (
  input  logic               aclk,
  input  logic               aresetn,
  rsp_if.snk                 rsp_i,
  output logic               m_tvalid_o,
  input  logic               m_tready_i,
  output usb_cmd_pkg::byte_t m_tdata_o,
  output logic               m_tlast_o
);
  import axi_pkg::*;
  import usb_cmd_pkg::*;

  typedef enum logic [2:0] {
    F_IDLE,
    F_CODE,
    F_TAG,
    F_DATA,
    F_BEAT  // Waiting for the next read beat
  } state_t;

  state_t     state;
  rsp_code_t  code_d;
  rsp_code_t  code_q;
  cmd_tag_t   tag_q;
  axi_data_t  beat_q;
  logic       last_q;
  logic       read_q;
  logic [1:0] byte_idx;
  logic       rsp_take;
  logic       byte_take;

  assign rsp_i.rsp_ready = (state == F_IDLE) || (state == F_BEAT);
  assign rsp_take   = rsp_i.rsp_valid && rsp_i.rsp_ready;
  assign m_tvalid_o = (state == F_CODE) || (state == F_TAG) || (state == F_DATA);
  assign byte_take  = m_tvalid_o && m_tready_i;

  // Read frames take their code from the first beat
  always_comb begin
    case (rsp_i.kind)
      KIND_RBEAT:  code_d = rsp_i.ok ? RSP_RDATA : RSP_RFAIL;
      KIND_REJECT: code_d = RSP_REJECT;
      default:     code_d = rsp_i.ok ? RSP_WDONE : RSP_WFAIL;
    endcase
  end

  always_comb begin
    case (state)
      F_CODE: begin
        m_tdata_o = code_q;
        m_tlast_o = 1'b0;
      end
      F_TAG: begin
        m_tdata_o = byte_t'(tag_q);
        m_tlast_o = !read_q;  // Status frames end here
      end
      default: begin
        m_tdata_o = beat_q[{byte_idx, 3'b000} +: 8];
        m_tlast_o = (state == F_DATA) && last_q && (byte_idx == 2'd3);
      end
    endcase
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state    <= F_IDLE;
      byte_idx <= '0;
      read_q   <= 1'b0;
      last_q   <= 1'b0;
    end else begin
      if (rsp_take) last_q <= rsp_i.last;
      case (state)
        F_IDLE: begin
          if (rsp_take) begin
            read_q <= (rsp_i.kind == KIND_RBEAT);
            state  <= F_CODE;
          end
        end
        F_CODE: if (byte_take) state <= F_TAG;
        F_TAG: begin
          if (byte_take) begin
            byte_idx <= '0;
            state    <= read_q ? F_DATA : F_IDLE;
          end
        end
        F_DATA: begin
          if (byte_take) begin
            byte_idx <= byte_idx + 2'd1;
            if (byte_idx == 2'd3) state <= last_q ? F_IDLE : F_BEAT;
          end
        end
        F_BEAT:  if (rsp_take) state <= F_DATA;
        default: state <= F_IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (rsp_take) begin
      beat_q <= rsp_i.data;
      if (state == F_IDLE) begin
        code_q <= code_d;
        tag_q  <= rsp_i.tag;
      end
    end
  end

endmodule

//--- source/usb_cmd_pkg.sv
package usb_cmd_pkg;

  typedef logic [3:0]  cmd_tag_t;
  typedef logic [15:0] cmd_waddr_t;  // Word address, 4-byte units
  typedef logic [7:0]  byte_t;
  typedef logic [7:0]  rsp_code_t;

  // First byte of every Bulk-In frame
  localparam rsp_code_t RSP_WDONE  = 8'h10;
  localparam rsp_code_t RSP_WFAIL  = 8'h11;
  localparam rsp_code_t RSP_RDATA  = 8'h20;
  localparam rsp_code_t RSP_RFAIL  = 8'h21;
  localparam rsp_code_t RSP_REJECT = 8'h30;

  // What the engine hands to the framer
  typedef enum logic [1:0] {
    KIND_WSTAT,
    KIND_RBEAT,
    KIND_REJECT
  } rsp_kind_t;

endpackage

//--- tests/axi_mem_slave.sv
`timescale 1ns/1ps

module axi_mem_slave #(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                  aclk_i,
  input  logic                  aresetn_i,
  input  logic                  awvalid_i,
  output logic                  awready_o,
  input  logic [ADDR_WIDTH-1:0] awaddr_i,
  input  logic [3:0]            awid_i,
  input  logic                  wvalid_i,
  output logic                  wready_o,
  input  logic [31:0]           wdata_i,
  input  logic                  wlast_i,
  output logic                  bvalid_o,
  input  logic                  bready_i,
  output logic [1:0]            bresp_o,
  output logic [3:0]            bid_o,
  input  logic                  arvalid_i,
  output logic                  arready_o,
  input  logic [ADDR_WIDTH-1:0] araddr_i,
  input  logic [3:0]            arid_i,
  input  logic [7:0]            arlen_i,
  output logic                  rvalid_o,
  input  logic                  rready_i,
  output logic [31:0]           rdata_o,
  output logic [1:0]            rresp_o,
  output logic [3:0]            rid_o,
  output logic                  rlast_o,
  output int                    aw_count_o,
  output int                    ar_count_o
);

  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic [31:0] mem [0:65535];
  logic        w_active;
  logic        w_err;      // Some beat of this burst hit the error region
  logic [15:0] w_word;
  logic        r_active;
  logic [15:0] r_word;
  logic [7:0]  r_len;
  logic [7:0]  r_cnt;
  logic [15:0] r_cur;

  function automatic logic in_err(input logic [15:0] word);
    return word >= 16'hF000;
  endfunction

  initial begin
    for (int i = 0; i < 65536; i++) begin
      mem[i] = {16'(i) ^ 16'hA5C3, ~16'(i)};
    end
  end

  assign r_cur = r_word + 16'(r_cnt);

  always @(posedge aclk_i or negedge aresetn_i) begin
    if (!aresetn_i) begin
      awready_o  <= 1'b0;
      wready_o   <= 1'b0;
      bvalid_o   <= 1'b0;
      bresp_o    <= 2'b00;
      bid_o      <= 4'h0;
      w_active   <= 1'b0;
      w_err      <= 1'b0;
      w_word     <= 16'h0000;
      arready_o  <= 1'b0;
      rvalid_o   <= 1'b0;
      rdata_o    <= 32'h0;
      rresp_o    <= 2'b00;
      rid_o      <= 4'h0;
      rlast_o    <= 1'b0;
      r_active   <= 1'b0;
      r_word     <= 16'h0000;
      r_len      <= 8'h00;
      r_cnt      <= 8'h00;
      aw_count_o <= 0;
      ar_count_o <= 0;
    end else begin
      // Write path
      awready_o <= !w_active && !(awvalid_i && awready_o) && ($urandom_range(0, 2) == 0);
      wready_o  <= w_active && !bvalid_o && ($urandom_range(0, 1) == 0);
      if (awvalid_i && awready_o) begin
        w_active   <= 1'b1;
        w_err      <= 1'b0;
        w_word     <= awaddr_i[17:2];
        bid_o      <= awid_i;
        aw_count_o <= aw_count_o + 1;
      end
      if (wvalid_i && wready_o) begin
        if (in_err(w_word)) w_err <= 1'b1;
        else mem[w_word] <= wdata_i;  // Error region is read only
        w_word <= w_word + 16'd1;
        if (wlast_i) begin
          bvalid_o <= 1'b1;
          bresp_o  <= (w_err || in_err(w_word)) ? RESP_SLVERR : 2'b00;
        end
      end
      if (bvalid_o && bready_i) begin
        bvalid_o <= 1'b0;
        w_active <= 1'b0;
      end
      // Read path with random gaps between beats
      arready_o <= !r_active && !(arvalid_i && arready_o) && ($urandom_range(0, 2) == 0);
      if (arvalid_i && arready_o) begin
        r_active   <= 1'b1;
        r_word     <= araddr_i[17:2];
        r_len      <= arlen_i;
        r_cnt      <= 8'h00;
        rid_o      <= arid_i;
        ar_count_o <= ar_count_o + 1;
      end
      if (rvalid_o && rready_i) begin
        rvalid_o <= 1'b0;
        r_cnt    <= r_cnt + 8'd1;
        if (rlast_o) r_active <= 1'b0;
      end else if (r_active && !rvalid_o && ($urandom_range(0, 3) != 0)) begin
        rvalid_o <= 1'b1;
        rdata_o  <= mem[r_cur];
        rresp_o  <= in_err(r_cur) ? RESP_SLVERR : 2'b00;
        rlast_o  <= (r_cnt == r_len);
      end
    end
  end

endmodule

//--- tests/cmd_to_axi_tb.sv
`timescale 1ns/1ps

module cmd_to_axi_tb;
  import usb_cmd_pkg::*;

  typedef logic [8:0] frame_q_t[$];  // {tlast, byte}

  logic        aclk;
  logic        aresetn;
  logic        cmd_valid_i, cmd_ready_o, cmd_dir_i;
  logic [3:0]  cmd_tag_i;
  logic [7:0]  cmd_len_i;
  logic [15:0] cmd_addr_i;
  logic        s_tvalid_i, s_tready_o;
  logic [7:0]  s_tdata_i;
  logic        m_tvalid_o, m_tready_i, m_tlast_o;
  logic [7:0]  m_tdata_o;
  logic        awvalid, awready, wvalid, wready, wlast, bvalid, bready;
  logic        arvalid, arready, rvalid, rready, rlast;
  logic [31:0] awaddr, araddr, wdata, rdata;
  logic [3:0]  awid, bid, arid, rid, wstrb;
  logic [7:0]  awlen, arlen;
  logic [1:0]  awburst, arburst, bresp, rresp;
  int          aw_count, ar_count;

  logic [31:0] shadow [0:65535];
  frame_q_t    exp_q;
  byte_t       wr_q[$];
  logic [27:0] aw_exp_q[$];  // {tag, len, word} per write burst
  logic [27:0] ar_exp_q[$];
  logic [31:0] w_exp_q[$];
  logic [7:0]  w_len;
  logic [7:0]  w_beat;
  logic        s_hs;
  logic        bp_en;
  int          errors, test_errors, tests_pass, tests_fail;
  int          cycles, limit, aw_before, ar_before;
  logic [7:0]  len;
  logic [15:0] waddr;
  logic [3:0]  tag;

  tb_clock_gen clock_gen_inst (.aclk_o(aclk), .aresetn_o(aresetn));

  cmd_to_axi #(.ADDR_WIDTH(32)) cmd_to_axi_inst (
    .aclk(aclk), .aresetn(aresetn),
    .cmd_valid_i(cmd_valid_i), .cmd_ready_o(cmd_ready_o), .cmd_dir_i(cmd_dir_i),
    .cmd_tag_i(cmd_tag_i), .cmd_len_i(cmd_len_i), .cmd_addr_i(cmd_addr_i),
    .s_tvalid_i(s_tvalid_i), .s_tready_o(s_tready_o), .s_tdata_i(s_tdata_i),
    .m_tvalid_o(m_tvalid_o), .m_tready_i(m_tready_i), .m_tdata_o(m_tdata_o),
    .m_tlast_o(m_tlast_o),
    .awvalid_o(awvalid), .awready_i(awready), .awaddr_o(awaddr), .awid_o(awid),
    .awlen_o(awlen), .awburst_o(awburst), .wvalid_o(wvalid), .wready_i(wready),
    .wdata_o(wdata), .wstrb_o(wstrb), .wlast_o(wlast), .bvalid_i(bvalid),
    .bready_o(bready), .bresp_i(bresp), .bid_i(bid), .arvalid_o(arvalid),
    .arready_i(arready), .araddr_o(araddr), .arid_o(arid), .arlen_o(arlen),
    .arburst_o(arburst), .rvalid_i(rvalid), .rready_o(rready), .rdata_i(rdata),
    .rresp_i(rresp), .rid_i(rid), .rlast_i(rlast)
  );

  axi_mem_slave #(.ADDR_WIDTH(32)) mem_inst (
    .aclk_i(aclk), .aresetn_i(aresetn),
    .awvalid_i(awvalid), .awready_o(awready), .awaddr_i(awaddr), .awid_i(awid),
    .wvalid_i(wvalid), .wready_o(wready), .wdata_i(wdata), .wlast_i(wlast),
    .bvalid_o(bvalid), .bready_i(bready), .bresp_o(bresp), .bid_o(bid),
    .arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr), .arid_i(arid),
    .arlen_i(arlen), .rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata),
    .rresp_o(rresp), .rid_o(rid), .rlast_o(rlast),
    .aw_count_o(aw_count), .ar_count_o(ar_count)
  );

  function automatic logic in_err(input logic [15:0] word);
    return word >= 16'hF000;
  endfunction

  function automatic logic crosses_4k(input logic [7:0] n, input logic [15:0] word);
    return ({1'b0, word[9:0]} + {3'b000, n}) > 11'd1023;
  endfunction

  // Bytes the bridge must send for one command
  function automatic frame_q_t expected_frame(input logic dir, input logic [3:0] t,
                                              input logic [7:0] n, input logic [15:0] word);
    frame_q_t    f;
    logic [15:0] w;
    logic        fail;
    fail = 1'b0;
    if (crosses_4k(n, word)) begin
      f.push_back({1'b0, RSP_REJECT});
      f.push_back({1'b1, 4'h0, t});
      return f;
    end
    for (int i = 0; i <= int'(n); i++) fail |= in_err(word + 16'(i));
    if (!dir) begin
      f.push_back({1'b0, fail ? RSP_WFAIL : RSP_WDONE});
      f.push_back({1'b1, 4'h0, t});
      return f;
    end
    f.push_back({1'b0, in_err(word) ? RSP_RFAIL : RSP_RDATA});  // First beat decides
    f.push_back({1'b0, 4'h0, t});
    for (int i = 0; i <= int'(n); i++) begin
      w = word + 16'(i);
      for (int b = 0; b < 4; b++) begin
        f.push_back({(i == int'(n)) && (b == 3), shadow[w][8*b +: 8]});
      end
    end
    return f;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else begin
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic issue(input logic dir, input logic [3:0] t, input logic [7:0] n,
                       input logic [15:0] word);
    frame_q_t    f;
    logic [31:0] data;
    int          wbytes;
    wbytes = 0;
    if (!dir && !crosses_4k(n, word)) begin
      for (int i = 0; i <= int'(n); i++) begin
        data = $urandom;
        for (int b = 0; b < 4; b++) wr_q.push_back(data[8*b +: 8]);
        w_exp_q.push_back(data);
        if (!in_err(word + 16'(i))) shadow[word + 16'(i)] = data;
      end
      wbytes = 4 * (int'(n) + 1);
    end
    if (!crosses_4k(n, word)) begin
      if (dir) ar_exp_q.push_back({t, n, word});
      else aw_exp_q.push_back({t, n, word});
    end
    f = expected_frame(dir, t, n, word);
    foreach (f[i]) exp_q.push_back(f[i]);
    limit += 200 + 64 * (f.size() + wbytes);
    cmd_valid_i = 1'b1;
    cmd_dir_i   = dir;
    cmd_tag_i   = t;
    cmd_len_i   = n;
    cmd_addr_i  = word;
    // Ready seen here means the transfer happens on the next rising edge
    while (!cmd_ready_o) @(negedge aclk);
    @(negedge aclk);
    cmd_valid_i = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0 || wr_q.size() != 0) @(negedge aclk);
    repeat (4) @(negedge aclk);
  endtask

  task automatic report_test(input string name);
    if (errors == test_errors) begin
      tests_pass++;
      $display("test %s: ok", name);
    end else begin
      tests_fail++;
      $display("test %s: %0d errors", name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  // Bulk-Out bytes and Bulk-In back-pressure
  always @(posedge aclk) s_hs = s_tvalid_i && s_tready_o;

  always @(negedge aclk) begin
    if (s_hs) void'(wr_q.pop_front());
    s_tvalid_i = wr_q.size() != 0;
    s_tdata_i  = (wr_q.size() != 0) ? wr_q[0] : 8'h00;
    m_tready_i = bp_en ? ($urandom_range(0, 3) != 0) : 1'b1;
  end

  // Compare every Bulk-In byte
  always @(posedge aclk) begin
    logic [8:0] e;
    if (aresetn && m_tvalid_o && m_tready_i) begin
      assert (exp_q.size() != 0) else begin
        $display("unexpected byte 0x%02h on the Bulk-In stream", m_tdata_o);
        errors++;
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        assert (m_tdata_o == e[7:0]) else begin
          $display("mismatch m_tdata_o: got 0x%02h, expected 0x%02h", m_tdata_o, e[7:0]);
          errors++;
        end
        assert (m_tlast_o == e[8]) else begin
          $display("mismatch m_tlast_o: got 0x%0h, expected 0x%0h", m_tlast_o, e[8]);
          errors++;
        end
      end
    end
  end

  // AXI requests against the issued commands
  always @(posedge aclk) begin
    logic [27:0] a;
    if (aresetn && awvalid && awready) begin
      assert (aw_exp_q.size() != 0) else begin
        $display("write burst on AW without a pending write command");
        errors++;
      end
      if (aw_exp_q.size() != 0) begin
        a = aw_exp_q.pop_front();
        check_value("awaddr", awaddr, {14'h0000, a[15:0], 2'b00});
        check_value("awid", 32'(awid), 32'(a[27:24]));
        check_value("awlen", 32'(awlen), 32'(a[23:16]));
        check_value("awburst", 32'(awburst), 32'h1);  // INCR
        w_len  = a[23:16];
        w_beat = 8'h00;
      end
    end
    if (aresetn && wvalid && wready) begin
      assert (w_exp_q.size() != 0) else begin
        $display("W beat without a pending write word");
        errors++;
      end
      if (w_exp_q.size() != 0) check_value("wdata", wdata, w_exp_q.pop_front());
      check_value("wstrb", 32'(wstrb), 32'hF);
      check_value("wlast", 32'(wlast), 32'(w_beat == w_len));
      w_beat = w_beat + 8'd1;
    end
    if (aresetn && arvalid && arready) begin
      assert (ar_exp_q.size() != 0) else begin
        $display("read burst on AR without a pending read command");
        errors++;
      end
      if (ar_exp_q.size() != 0) begin
        a = ar_exp_q.pop_front();
        check_value("araddr", araddr, {14'h0000, a[15:0], 2'b00});
        check_value("arid", 32'(arid), 32'(a[27:24]));
        check_value("arlen", 32'(arlen), 32'(a[23:16]));
        check_value("arburst", 32'(arburst), 32'h1);
      end
    end
  end

  always @(posedge aclk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, the bridge stopped making progress", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hd7894a31));
    cmd_valid_i = 1'b0;
    cmd_dir_i   = 1'b0;
    cmd_tag_i   = 4'h0;
    cmd_len_i   = 8'h00;
    cmd_addr_i  = 16'h0000;
    s_tvalid_i  = 1'b0;
    s_tdata_i   = 8'h00;
    m_tready_i  = 1'b0;
    s_hs        = 1'b0;
    bp_en       = 1'b0;
    w_len       = 8'h00;
    w_beat      = 8'h00;
    errors      = 0;
    test_errors = 0;
    tests_pass  = 0;
    tests_fail  = 0;
    cycles      = 0;
    limit       = 200;  // Reset and settling
    for (int i = 0; i < 65536; i++) shadow[i] = {16'(i) ^ 16'hA5C3, ~16'(i)};

    @(negedge aclk);
    assert (!m_tvalid_o && !awvalid && !arvalid && !wvalid) else begin
      $display("a valid output is high during reset");
      errors++;
    end
    wait (aresetn);
    @(negedge aclk);
    assert (cmd_ready_o && !m_tvalid_o && !awvalid && !arvalid && !wvalid &&
            !s_tready_o && !bready && !rready) else begin
      $display("handshake outputs not idle after reset");
      errors++;
    end
    report_test("reset");

    issue(1'b0, 4'h3, 8'd0, 16'h0100);
    issue(1'b1, 4'h4, 8'd0, 16'h0100);
    drain();
    report_test("single beat round trip");

    bp_en = 1'b1;
    repeat (12) begin
      len   = 8'($urandom_range(0, 15));
      waddr = {6'($urandom_range(0, 59)), 10'($urandom_range(0, 1008))};
      tag   = 4'($urandom);
      issue(1'b0, tag, len, waddr);
      issue(1'b1, tag + 4'd1, len, waddr);  // Queued behind the write
    end
    drain();
    bp_en = 1'b0;
    report_test("random bursts");

    issue(1'b0, 4'hA, 8'd1, 16'hF010);
    issue(1'b1, 4'hB, 8'd1, 16'hF010);
    drain();
    report_test("slave errors");

    aw_before = aw_count;
    ar_before = ar_count;
    issue(1'b0, 4'hC, 8'd3, 16'h03FE);
    issue(1'b1, 4'hD, 8'd1, 16'h07FF);
    drain();
    assert (aw_count == aw_before && ar_count == ar_before) else begin
      $display("rejected commands reached the AXI address channels");
      errors++;
    end
    report_test("boundary rejection");

    $display("tests passed: %0d, failed: %0d", tests_pass, tests_fail);
    if (tests_fail == 0 && errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic aclk_o,
  output logic aresetn_o
);

  initial begin
    aclk_o    = 1'b0;
    aresetn_o = 1'b0;
    repeat (3) @(posedge aclk_o);
    @(negedge aclk_o);
    aresetn_o = 1'b1;  // Release away from the active edge
  end

  always #2 aclk_o = ~aclk_o;  // 4 ns period

endmodule
